// ==== tb/idu_vectors_input.txt ====
# columns: instr pc op imm use_imm wb_vld, all hex
# op is the alu_op_e index, e.g. 00 add, 12 lw, 1a jal, 1c nop
002081b3 00001000 00 00000000 0 1
404182b3 00001004 01 00000000 0 1
4012d333 00001008 07 00000000 0 1
ffb10393 0000100c 00 fffffffb 1 1
00419093 00001010 02 00000004 1 1
4030d113 00001014 07 00000403 1 1
0080a203 00001018 12 00000008 1 1
fe21ae23 0000101c 17 fffffffc 0 0
00208863 00001020 0a 00000010 0 0
fe419ce3 00001024 0b fffffff8 0 0
12345437 00001028 18 12345000 1 1
fffff497 0000102c 19 fffff000 1 1
0010006f 00001030 1a 00000800 1 1
ffdff06f 00001034 1a fffffffc 1 1
00c280e7 00001038 1b 0000000c 1 1
0000007f 0000103c 1c 00000000 0 0
02c58533 00001040 1c 00000000 0 1
00004183 00001044 13 00000000 1 1

// ==== tb.f ====
logic/rv_isa_pkg.sv
logic/idu_pipe_pkg.sv
logic/rv_inst_decoder.sv
logic/operand_bypass.sv
logic/decode_stage_reg.sv
logic/idu_top.sv
tb/tb_clkgen.sv
tb/tb_idu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_idu --Mdir obj_dir -o vtb_idu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vtb_idu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== tb/tb_idu.sv ====
`timescale 1ns/1ps

module tb_idu;
    import rv_isa_pkg::*;
    import idu_pipe_pkg::*;

    localparam int reset_cycles = 8;
    localparam int drive_delay = 2;

    logic       clk;
    logic       arst_n;
    logic       fetch_vld;
    logic       fetch_rdy;
    logic       flush;
    logic       alu_rdy;
    logic       uop_vld;
    fetch_pkt_t fetch;
    wb_port_t   alu_wb;
    wb_port_t   lsu_wb;
    wb_port_t   rf_wb;
    reg_addr_t  rf_rs1_addr;
    reg_addr_t  rf_rs2_addr;
    xword_t     rf_rs1_data;
    xword_t     rf_rs2_data;
    uop_t       uop;

    xword_t      vec_instr[$];
    xword_t      vec_pc[$];
    dec_info_t   vec_info[$];
    logic [15:0] lfsr;
    logic        model_vld;
    uop_t        model_uop;
    int          vec_idx;
    int          err_cnt;
    int          chk_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    int          accepted;
    int          departed;
    int          dropped;
    int          hazards;

    tb_clkgen clkgen0 (.clk_o(clk), .arst_n_o(arst_n));

    idu_top dut0 (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .fetch_vld_i   (fetch_vld),
        .fetch_i       (fetch),
        .fetch_rdy_o   (fetch_rdy),
        .alu_wb_i      (alu_wb),
        .lsu_wb_i      (lsu_wb),
        .rf_wb_i       (rf_wb),
        .rf_rs1_addr_o (rf_rs1_addr),
        .rf_rs2_addr_o (rf_rs2_addr),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .flush_i       (flush),
        .alu_rdy_i     (alu_rdy),
        .uop_vld_o     (uop_vld),
        .uop_o         (uop)
    );

    // 16-bit fibonacci, taps 16 14 13 11
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_rand_bit()};
        end
        return v;
    endfunction

    // bias port addresses toward the sources so forwarding actually hits
    function automatic reg_addr_t pick_addr(xword_t instr);
        logic [1:0] sel;
        reg_addr_t  a;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0: a = instr[19:15];
            2'd1: a = instr[24:20];
            2'd2: a = '0;
            default: a = 5'(rand_bits(5));
        endcase
        return a;
    endfunction

    function automatic wb_port_t rand_port(xword_t instr);
        wb_port_t p;
        p.vld   = next_rand_bit();
        p.is_ld = next_rand_bit();
        p.addr  = pick_addr(instr);
        p.data  = rand_bits(32);
        return p;
    endfunction

    function automatic logic reads_rs1(xword_t instr);
        return instr[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_STORE, OPC_BRANCH};
    endfunction

    function automatic logic reads_rs2(xword_t instr);
        return instr[6:0] inside {OPC_OP, OPC_STORE, OPC_BRANCH};
    endfunction

    function automatic xword_t expect_src(logic used, reg_addr_t a, xword_t rf_data);
        xword_t v;
        v = rf_data;
        if (used && a != '0) begin
            if (alu_wb.vld && alu_wb.addr == a) v = alu_wb.data;
            else if (lsu_wb.vld && lsu_wb.addr == a) v = lsu_wb.data;
            else if (rf_wb.vld && rf_wb.addr == a) v = rf_wb.data;
        end
        return v;
    endfunction

    function automatic logic load_pending_on(logic used, reg_addr_t a);
        return used && a != '0 && lsu_wb.vld && lsu_wb.is_ld && lsu_wb.addr == a;
    endfunction

    task automatic check_info(dec_info_t got, dec_info_t exp, string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s: got %s %h %b %0d, expected %s %h %b %0d",
                     $time, what, got.op.name(), got.imm,
                     {got.use_imm, got.use_rs1, got.use_rs2, got.wb_vld}, got.rd,
                     exp.op.name(), exp.imm,
                     {exp.use_imm, exp.use_rs1, exp.use_rs2, exp.wb_vld}, exp.rd);
        end
    endtask

    task automatic check_word(xword_t got, xword_t exp, string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_inputs();
        if (vec_idx < vec_instr.size()) begin
            fetch.instr = vec_instr[vec_idx];
            fetch.pc    = vec_pc[vec_idx];
            fetch_vld   = (rand_bits(2) != 0);
        end else begin
            fetch_vld = 1'b0;
        end
        alu_wb      = rand_port(fetch.instr);
        lsu_wb      = rand_port(fetch.instr);
        rf_wb       = rand_port(fetch.instr);
        rf_rs1_data = rand_bits(32);
        rf_rs2_data = rand_bits(32);
        alu_rdy     = next_rand_bit();
        flush       = (rand_bits(4) == 0);
    endtask

    // compares at the falling edge, then steps the model for the next rising edge
    task automatic check_cycle();
        logic      hz;
        logic      exp_rdy;
        dec_info_t info;
        hz = load_pending_on(reads_rs1(fetch.instr), fetch.instr[19:15])
           || load_pending_on(reads_rs2(fetch.instr), fetch.instr[24:20]);
        exp_rdy = (!model_vld || alu_rdy) && !hz;
        check_word(xword_t'(fetch_rdy), xword_t'(exp_rdy), "fetch_rdy_o");
        check_word(xword_t'(uop_vld), xword_t'(model_vld), "uop_vld_o");
        check_word(xword_t'(rf_rs1_addr), xword_t'(fetch.instr[19:15]), "rf_rs1_addr_o");
        check_word(xword_t'(rf_rs2_addr), xword_t'(fetch.instr[24:20]), "rf_rs2_addr_o");
        if (model_vld) begin
            check_info(uop.info, model_uop.info, "uop info");
            check_word(uop.src1, model_uop.src1, "uop src1");
            check_word(uop.src2, model_uop.src2, "uop src2");
            check_word(uop.pc, model_uop.pc, "uop pc");
        end
        if (hz && fetch_vld) hazards++;
        // count what the dut actually hands over or drops
        if (uop_vld && flush) dropped++;
        else if (uop_vld && alu_rdy) departed++;
        if (flush) begin
            model_vld = 1'b0;
        end else if (fetch_vld && exp_rdy) begin
            info           = vec_info[vec_idx];
            model_uop.info = info;
            model_uop.src1 = expect_src(info.use_rs1, fetch.instr[19:15], rf_rs1_data);
            model_uop.src2 = info.use_imm ? info.imm
                           : expect_src(info.use_rs2, fetch.instr[24:20], rf_rs2_data);
            model_uop.pc   = vec_pc[vec_idx];
            model_vld      = 1'b1;
            vec_idx++;
            accepted++;
        end else if (alu_rdy) begin
            model_vld = 1'b0;
        end
    endtask

    task automatic load_vectors();
        int        fd;
        int        n;
        string     line;
        xword_t    f_instr;
        xword_t    f_pc;
        xword_t    f_op;
        xword_t    f_imm;
        xword_t    f_ui;
        xword_t    f_wb;
        dec_info_t info;
        fd = $fopen("tb/idu_vectors_input.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 10 || line[0] == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h", f_instr, f_pc, f_op, f_imm, f_ui, f_wb);
            if (n != 6) continue;
            info.op      = alu_op_e'(f_op[4:0]);
            info.imm     = f_imm;
            info.use_imm = f_ui[0];
            info.use_rs1 = reads_rs1(f_instr);
            info.use_rs2 = reads_rs2(f_instr);
            info.wb_vld  = f_wb[0];
            info.rd      = f_instr[11:7];
            vec_instr.push_back(f_instr);
            vec_pc.push_back(f_pc);
            vec_info.push_back(info);
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d vectors accepted",
                     cycle_cnt, accepted, vec_instr.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        lfsr = 16'd46803;
        fetch_vld = 1'b0;
        fetch = '0;
        alu_wb = '0;
        lsu_wb = '0;
        rf_wb = '0;
        rf_rs1_data = '0;
        rf_rs2_data = '0;
        flush = 1'b0;
        alu_rdy = 1'b0;
        model_vld = 1'b0;
        model_uop = '0;
        vec_idx = 0;
        err_cnt = 0;
        chk_cnt = 0;
        cycle_cnt = 0;
        accepted = 0;
        departed = 0;
        dropped = 0;
        hazards = 0;
        cycle_limit = 1000;
        load_vectors();
        if (vec_instr.size() == 0) begin
            $display("no vectors could be read from tb/idu_vectors_input.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            cycle_limit = 20 * vec_instr.size() + reset_cycles;
            repeat (reset_cycles) begin
                @(negedge clk);
                check_word(xword_t'(uop_vld), '0, "uop_vld_o in reset");
            end
            wait (arst_n === 1'b1);
            while (vec_idx < vec_instr.size() || model_vld) begin
                @(posedge clk);
                #drive_delay;
                drive_inputs();
                @(negedge clk);
                check_cycle();
            end
            check_word(xword_t'(departed + dropped), xword_t'(accepted), "uops leaving the stage");
            $display("errors %0d, checks %0d, accepted %0d, departed %0d, dropped %0d, hazards %0d",
                     err_cnt, chk_cnt, accepted, departed, dropped, hazards);
            if (err_cnt == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic arst_n_o
);
    localparam int half_period = 20;
    localparam int reset_cycles = 8;

    initial begin
        clk_o = 1'b0;
        forever #half_period clk_o = ~clk_o;
    end

    // release just after an edge so it never races the flops
    initial begin
        arst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #2;
        arst_n_o = 1'b1;
    end

endmodule

// ==== logic/idu_top.sv ====
`timescale 1ns/1ps

module idu_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     fetch_vld_i,
    input  idu_pipe_pkg::fetch_pkt_t fetch_i,
    output logic                     fetch_rdy_o,
    input  idu_pipe_pkg::wb_port_t   alu_wb_i,
    input  idu_pipe_pkg::wb_port_t   lsu_wb_i,
    input  idu_pipe_pkg::wb_port_t   rf_wb_i,
    output rv_isa_pkg::reg_addr_t    rf_rs1_addr_o,
    output rv_isa_pkg::reg_addr_t    rf_rs2_addr_o,
    input  rv_isa_pkg::xword_t       rf_rs1_data_i,
    input  rv_isa_pkg::xword_t       rf_rs2_data_i,
    input  logic                     flush_i,
    input  logic                     alu_rdy_i,
    output logic                     uop_vld_o,
    output idu_pipe_pkg::uop_t       uop_o
);
    import rv_isa_pkg::*;
    import idu_pipe_pkg::*;

    dec_info_t dec_info;
    xword_t    rs1_val;
    xword_t    rs2_val;
    logic      ld_hazard;

    rv_inst_decoder u_decoder (
        .instr_i (fetch_i.instr),
        .info_o  (dec_info)
    );

    // operands read in the same cycle as decode
    operand_bypass u_bypass (
        .instr_i       (fetch_i.instr),
        .use_rs1_i     (dec_info.use_rs1),
        .use_rs2_i     (dec_info.use_rs2),
        .alu_wb_i      (alu_wb_i),
        .lsu_wb_i      (lsu_wb_i),
        .rf_wb_i       (rf_wb_i),
        .rf_rs1_data_i (rf_rs1_data_i),
        .rf_rs2_data_i (rf_rs2_data_i),
        .rf_rs1_addr_o (rf_rs1_addr_o),
        .rf_rs2_addr_o (rf_rs2_addr_o),
        .rs1_val_o     (rs1_val),
        .rs2_val_o     (rs2_val),
        .ld_hazard_o   (ld_hazard)
    );

    decode_stage_reg u_stage (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .fetch_vld_i (fetch_vld_i),
        .fetch_i     (fetch_i),
        .info_i      (dec_info),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .ld_hazard_i (ld_hazard),
        .flush_i     (flush_i),
        .alu_rdy_i   (alu_rdy_i),
        .fetch_rdy_o (fetch_rdy_o),
        .uop_vld_o   (uop_vld_o),
        .uop_o       (uop_o)
    );

endmodule

// ==== logic/decode_stage_reg.sv ====
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     fetch_vld_i,
    input  idu_pipe_pkg::fetch_pkt_t fetch_i,
    input  idu_pipe_pkg::dec_info_t  info_i,
    input  rv_isa_pkg::xword_t       rs1_val_i,
    input  rv_isa_pkg::xword_t       rs2_val_i,
    input  logic                     ld_hazard_i,
    input  logic                     flush_i,
    input  logic                     alu_rdy_i,
    output logic                     fetch_rdy_o,
    output logic                     uop_vld_o,
    output idu_pipe_pkg::uop_t       uop_o
);
    import rv_isa_pkg::*;
    import idu_pipe_pkg::*;

    logic   accept;
    xword_t src2_sel;
    uop_t   uop_nxt;

    // room when empty or the held uop leaves this cycle
    assign fetch_rdy_o = (!uop_vld_o || alu_rdy_i) && !ld_hazard_i;
    assign accept      = fetch_vld_i && fetch_rdy_o && !flush_i;

    assign src2_sel = info_i.use_imm ? info_i.imm : rs2_val_i;

    assign uop_nxt = '{
        info: info_i,
        src1: rs1_val_i,
        src2: src2_sel,
        pc:   fetch_i.pc
    };

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            uop_vld_o <= 1'b0;
        end else if (flush_i) begin
            uop_vld_o <= 1'b0;
        end else if (accept) begin
            uop_vld_o <= 1'b1;
        end else if (alu_rdy_i) begin
            uop_vld_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            uop_o <= uop_nxt;
        end
    end

    a_hold_under_backpressure: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        uop_vld_o && !alu_rdy_i && !flush_i |=> uop_vld_o && $stable(uop_o)
    ) else $error("uop changed while the alu was not ready");

    a_flush_empties_stage: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        flush_i |=> !uop_vld_o
    ) else $error("uop still valid after flush");

endmodule

// ==== logic/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
    input  rv_isa_pkg::xword_t     instr_i,
    input  logic                   use_rs1_i,
    input  logic                   use_rs2_i,
    input  idu_pipe_pkg::wb_port_t alu_wb_i,
    input  idu_pipe_pkg::wb_port_t lsu_wb_i,
    input  idu_pipe_pkg::wb_port_t rf_wb_i,
    input  rv_isa_pkg::xword_t     rf_rs1_data_i,
    input  rv_isa_pkg::xword_t     rf_rs2_data_i,
    output rv_isa_pkg::reg_addr_t  rf_rs1_addr_o,
    output rv_isa_pkg::reg_addr_t  rf_rs2_addr_o,
    output rv_isa_pkg::xword_t     rs1_val_o,
    output rv_isa_pkg::xword_t     rs2_val_o,
    output logic                   ld_hazard_o
);
    import rv_isa_pkg::*;
    import idu_pipe_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;

    // x0 is hardwired, never take it from a writeback port
    function automatic logic port_hit(wb_port_t port, reg_addr_t addr);
        return port.vld && (port.addr == addr) && (addr != '0);
    endfunction

    // youngest result first: alu, then lsu, then rf write port
    function automatic xword_t fwd_value(logic used, reg_addr_t addr, xword_t rf_data,
                                         wb_port_t alu, wb_port_t lsu, wb_port_t rf);
        xword_t val;
        val = rf_data;
        if (used && port_hit(alu, addr)) begin
            val = alu.data;
        end else if (used && port_hit(lsu, addr)) begin
            val = lsu.data;
        end else if (used && port_hit(rf, addr)) begin
            val = rf.data;
        end
        return val;
    endfunction

    assign rs1_addr = instr_i[RS1_MSB:RS1_LSB];
    assign rs2_addr = instr_i[RS2_MSB:RS2_LSB];

    assign rf_rs1_addr_o = rs1_addr;
    assign rf_rs2_addr_o = rs2_addr;

    assign rs1_val_o = fwd_value(use_rs1_i, rs1_addr, rf_rs1_data_i, alu_wb_i, lsu_wb_i, rf_wb_i);
    assign rs2_val_o = fwd_value(use_rs2_i, rs2_addr, rf_rs2_data_i, alu_wb_i, lsu_wb_i, rf_wb_i);

    // load data not back yet, stage must wait
    assign ld_hazard_o = lsu_wb_i.is_ld
                       && ((use_rs1_i && port_hit(lsu_wb_i, rs1_addr))
                       ||  (use_rs2_i && port_hit(lsu_wb_i, rs2_addr)));

endmodule

// ==== logic/rv_inst_decoder.sv ====
`timescale 1ns/1ps

module rv_inst_decoder (
    input  rv_isa_pkg::xword_t      instr_i,
    output idu_pipe_pkg::dec_info_t info_o
);
    import rv_isa_pkg::*;
    import idu_pipe_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_norm;
    logic       f7_alt;
    logic       is_reg;
    logic       arith_ok;

    logic       fmt_r;
    logic       fmt_i;
    logic       fmt_s;
    logic       fmt_b;
    logic       fmt_u;
    logic       fmt_j;

    xword_t     imm_i;
    xword_t     imm_s;
    xword_t     imm_b;
    xword_t     imm_u;
    xword_t     imm_j;
    alu_op_e    op;

    assign opcode = opcode_e'(instr_i[OPC_MSB:OPC_LSB]);
    assign funct3 = instr_i[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = instr_i[FUNCT7_MSB:FUNCT7_LSB];

    assign f7_norm  = (funct7 == FUNCT7_NORM);
    assign f7_alt   = (funct7 == FUNCT7_ALT);
    assign is_reg   = (opcode == OPC_OP);
    // immediate forms ignore funct7 except for shifts
    assign arith_ok = !is_reg || f7_norm;

    assign fmt_r = (opcode == OPC_OP);
    assign fmt_i = (opcode == OPC_OP_IMM) || (opcode == OPC_LOAD) || (opcode == OPC_JALR);
    assign fmt_s = (opcode == OPC_STORE);
    assign fmt_b = (opcode == OPC_BRANCH);
    assign fmt_u = (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
    assign fmt_j = (opcode == OPC_JAL);

    assign imm_i = {{(xlen-I_IMM_SIZE){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(xlen-S_IMM_SIZE){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(xlen-B_IMM_SIZE){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], {(xlen-U_IMM_SIZE){1'b0}}};
    assign imm_j = {{(xlen-J_IMM_SIZE){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        op = ALU_NOP;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                case (funct3)
                    FUNCT3_ADD:  op = (is_reg && f7_alt) ? ALU_SUB : (arith_ok ? ALU_ADD : ALU_NOP);
                    FUNCT3_SLL:  op = f7_norm ? ALU_SLL : ALU_NOP;
                    FUNCT3_SLT:  op = arith_ok ? ALU_SLT : ALU_NOP;
                    FUNCT3_SLTU: op = arith_ok ? ALU_SLTU : ALU_NOP;
                    FUNCT3_XOR:  op = arith_ok ? ALU_XOR : ALU_NOP;
                    FUNCT3_SR:   op = f7_alt ? ALU_SRA : (f7_norm ? ALU_SRL : ALU_NOP);
                    FUNCT3_OR:   op = arith_ok ? ALU_OR : ALU_NOP;
                    FUNCT3_AND:  op = arith_ok ? ALU_AND : ALU_NOP;
                    default:     op = ALU_NOP;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    FUNCT3_ADD: op = ALU_BEQ;
                    FUNCT3_SLL: op = ALU_BNE;
                    FUNCT3_XOR: op = ALU_BLT;
                    FUNCT3_SR:  op = ALU_BGE;
                    FUNCT3_OR:  op = ALU_BLTU;
                    FUNCT3_AND: op = ALU_BGEU;
                    default:    op = ALU_NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    FUNCT3_ADD: op = ALU_LB;
                    FUNCT3_SLL: op = ALU_LH;
                    FUNCT3_SLT: op = ALU_LW;
                    FUNCT3_XOR: op = ALU_LBU;
                    FUNCT3_SR:  op = ALU_LHU;
                    default:    op = ALU_NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    FUNCT3_ADD: op = ALU_SB;
                    FUNCT3_SLL: op = ALU_SH;
                    FUNCT3_SLT: op = ALU_SW;
                    default:    op = ALU_NOP;
                endcase
            end
            OPC_LUI:   op = ALU_LUI;
            OPC_AUIPC: op = ALU_AUIPC;
            OPC_JAL:   op = ALU_JAL;
            OPC_JALR:  op = (funct3 == FUNCT3_ADD) ? ALU_JALR : ALU_NOP;
            default:   op = ALU_NOP;
        endcase
    end

    assign info_o.op      = op;
    // formats are one-hot, so and-or selection is enough
    assign info_o.imm     = ({xlen{fmt_i}} & imm_i) | ({xlen{fmt_s}} & imm_s)
                          | ({xlen{fmt_b}} & imm_b) | ({xlen{fmt_u}} & imm_u)
                          | ({xlen{fmt_j}} & imm_j);
    assign info_o.use_imm = fmt_i || fmt_u || fmt_j;
    assign info_o.use_rs1 = fmt_r || fmt_i || fmt_s || fmt_b;
    assign info_o.use_rs2 = fmt_r || fmt_s || fmt_b;
    assign info_o.wb_vld  = fmt_r || fmt_i || fmt_u || fmt_j;
    assign info_o.rd      = instr_i[RD_MSB:RD_LSB];

endmodule

// ==== logic/idu_pipe_pkg.sv ====
package idu_pipe_pkg;

    import rv_isa_pkg::*;

    // packet offered by fetch
    typedef struct packed {
        xword_t instr;
        xword_t pc;
    } fetch_pkt_t;

    // one writeback path, is_ld only meaningful on the lsu port
    typedef struct packed {
        logic      vld;
        logic      is_ld;
        reg_addr_t addr;
        xword_t    data;
    } wb_port_t;

    // decoder result, before operands are attached
    typedef struct packed {
        alu_op_e   op;
        xword_t    imm;
        logic      use_imm;
        logic      use_rs1;
        logic      use_rs2;
        logic      wb_vld;
        reg_addr_t rd;
    } dec_info_t;

    // micro-op handed to the alu
    typedef struct packed {
        dec_info_t info;
        xword_t    src1;
        xword_t    src2;
        xword_t    pc;
    } uop_t;

endpackage

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] xword_t;

    // base RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // funct3 values, reused by branch, load and store groups
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    localparam logic [6:0] FUNCT7_NORM = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    // instruction field positions
    localparam int OPC_LSB    = 0;
    localparam int OPC_MSB    = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int FUNCT7_LSB = 25;
    localparam int FUNCT7_MSB = 31;

    // immediate widths before extension, b and j include the implicit zero lsb
    localparam int I_IMM_SIZE = 12;
    localparam int S_IMM_SIZE = 12;
    localparam int B_IMM_SIZE = 13;
    localparam int U_IMM_SIZE = 20;
    localparam int J_IMM_SIZE = 21;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_NOP
    } alu_op_e;

endpackage
